// ==== aluPkg.sv ====
// ALU widths, command opcodes, result selects and request/control/response structs
package aluPkg;

    localparam int dataWidth  = 32;
    localparam int sliceWidth = 8;
    localparam int sliceCount = dataWidth / sliceWidth;
    localparam int cmdWidth   = 3;

    // command encodings, same as the MIPS subset
    localparam logic [cmdWidth-1:0] opAdd  = 3'd0;
    localparam logic [cmdWidth-1:0] opSub  = 3'd1;
    localparam logic [cmdWidth-1:0] opXor  = 3'd2;
    localparam logic [cmdWidth-1:0] opSlt  = 3'd3;
    localparam logic [cmdWidth-1:0] opAnd  = 3'd4;
    localparam logic [cmdWidth-1:0] opNand = 3'd5;
    localparam logic [cmdWidth-1:0] opNor  = 3'd6;
    localparam logic [cmdWidth-1:0] opOr   = 3'd7;

    // which operation output lands in the result word
    localparam logic [2:0] selSum  = 3'd0;
    localparam logic [2:0] selXor  = 3'd1;
    localparam logic [2:0] selSlt  = 3'd2;
    localparam logic [2:0] selNand = 3'd3;
    localparam logic [2:0] selNor  = 3'd4;

    typedef struct packed {
        logic [dataWidth-1:0] operandA;
        logic [dataWidth-1:0] operandB;
        logic [cmdWidth-1:0]  command;
    } aluRequestT;

    typedef struct packed {
        logic [2:0] resultSel;
        logic       invertA;
        logic       invertB;   // doubles as carry into bit 0
    } aluControlT;

    typedef struct packed {
        logic [dataWidth-1:0] result;
        logic                 carryout;
        logic                 zero;
        logic                 overflow;
    } aluResponseT;

endpackage

// ==== aluControlDecoder.sv ====
// ALU input stage: command lookup table, operand inverters and first pipeline register
module aluControlDecoder (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           inValid,
    input  aluPkg::aluRequestT             request,
    output logic                           stageValid,
    output aluPkg::aluControlT             control,
    output logic [aluPkg::dataWidth-1:0]   inputA,
    output logic [aluPkg::dataWidth-1:0]   inputB
);

    aluPkg::aluControlT            nextControl;
    logic [aluPkg::dataWidth-1:0]  nextA;
    logic [aluPkg::dataWidth-1:0]  nextB;

    // command lookup table
    // and/or reuse nor/nand with both operands inverted (De Morgan)
    always_comb begin
        nextControl = '0;
        case (request.command)
            aluPkg::opAdd: begin
                nextControl = '{resultSel: aluPkg::selSum, invertA: 1'b0, invertB: 1'b0};
            end
            aluPkg::opSub: begin
                nextControl = '{resultSel: aluPkg::selSum, invertA: 1'b0, invertB: 1'b1};
            end
            aluPkg::opXor: begin
                nextControl = '{resultSel: aluPkg::selXor, invertA: 1'b0, invertB: 1'b0};
            end
            aluPkg::opSlt: begin
                nextControl = '{resultSel: aluPkg::selSlt, invertA: 1'b0, invertB: 1'b1};
            end
            aluPkg::opAnd: begin
                nextControl = '{resultSel: aluPkg::selNor, invertA: 1'b1, invertB: 1'b1};
            end
            aluPkg::opNor: begin
                nextControl = '{resultSel: aluPkg::selNor, invertA: 1'b0, invertB: 1'b0};
            end
            aluPkg::opNand: begin
                nextControl = '{resultSel: aluPkg::selNand, invertA: 1'b0, invertB: 1'b0};
            end
            aluPkg::opOr: begin
                nextControl = '{resultSel: aluPkg::selNand, invertA: 1'b1, invertB: 1'b1};
            end
            default: begin
                nextControl = '0;   // unknown command falls back to add
            end
        endcase
    end

    // conditional inversion ahead of every operation
    assign nextA = request.operandA ^ {aluPkg::dataWidth{nextControl.invertA}};
    assign nextB = request.operandB ^ {aluPkg::dataWidth{nextControl.invertB}};

    always_ff @(posedge clk) begin
        if (reset) begin
            stageValid <= 1'b0;
        end else begin
            stageValid <= inValid;
        end
    end

    // payload only moves on an accepted request
    always_ff @(posedge clk) begin
        if (inValid) begin
            control <= nextControl;
            inputA  <= nextA;
            inputB  <= nextB;
        end
    end

    // an accepted request must carry a defined command
    assert property (@(posedge clk) disable iff (reset)
        inValid |-> !$isunknown(request.command));

endmodule

// ==== aluSlice.sv ====
// one ALU bit slice: ripple-carry adder bits, xor, nand, nor and the slice result mux
module aluSlice (
    input  logic [aluPkg::sliceWidth-1:0] a,
    input  logic [aluPkg::sliceWidth-1:0] b,
    input  logic                          carryIn,
    input  logic [2:0]                    resultSel,
    output logic [aluPkg::sliceWidth-1:0] sliceResult,
    output logic [aluPkg::sliceWidth-1:0] sum,
    output logic                          carryOut,
    output logic                          msbCarryIn
);

    logic [aluPkg::sliceWidth:0]   carry;       // carry[i] feeds bit i
    logic [aluPkg::sliceWidth-1:0] xorBits;
    logic [aluPkg::sliceWidth-1:0] nandBits;
    logic [aluPkg::sliceWidth-1:0] norBits;

    // full adder per bit, carry ripples upward
    always_comb begin
        carry[0] = carryIn;
        for (int i = 0; i < aluPkg::sliceWidth; i++) begin
            sum[i]     = a[i] ^ b[i] ^ carry[i];
            carry[i+1] = (a[i] & b[i]) | ((a[i] ^ b[i]) & carry[i]);
        end
    end

    assign carryOut   = carry[aluPkg::sliceWidth];
    assign msbCarryIn = carry[aluPkg::sliceWidth-1];   // for overflow at the top slice

    // bitwise units, operands already inverted upstream
    assign xorBits  = a ^ b;
    assign nandBits = ~(a & b);
    assign norBits  = ~(a | b);

    // slt takes the sum here, the collector rebuilds the word
    always_comb begin
        case (resultSel)
            aluPkg::selSum: begin
                sliceResult = sum;
            end
            aluPkg::selSlt: begin
                sliceResult = sum;
            end
            aluPkg::selXor: begin
                sliceResult = xorBits;
            end
            aluPkg::selNand: begin
                sliceResult = nandBits;
            end
            aluPkg::selNor: begin
                sliceResult = norBits;
            end
            default: begin
                sliceResult = '0;
            end
        endcase
    end

endmodule

// ==== aluResultCollector.sv ====
// ALU output stage: slice join, set-less-than, flag gating, zero detect and response register
module aluResultCollector (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stageValid,
    input  logic [2:0]                    resultSel,
    input  logic [aluPkg::dataWidth-1:0]  sliceResults,
    input  logic                          sumMsb,
    input  logic                          carryOut,
    input  logic                          msbCarryIn,
    output logic                          outValid,
    output aluPkg::aluResponseT           response
);

    logic                         adderOverflow;
    logic                         isArith;
    logic                         lessThan;
    logic [aluPkg::dataWidth-1:0] finalResult;
    aluPkg::aluResponseT          nextResponse;

    // signed overflow from the carries around the top bit
    assign adderOverflow = msbCarryIn ^ carryOut;
    assign isArith       = (resultSel == aluPkg::selSum);

    // with overflow the sign bit of a-b is flipped
    assign lessThan = sumMsb ^ adderOverflow;

    always_comb begin
        if (resultSel == aluPkg::selSlt) begin
            finalResult    = '0;
            finalResult[0] = lessThan;
        end else begin
            finalResult = sliceResults;
        end
    end

    always_comb begin
        nextResponse.result   = finalResult;
        nextResponse.carryout = carryOut & isArith;        // add and sub only
        nextResponse.overflow = adderOverflow & isArith;
        nextResponse.zero     = (finalResult == '0);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else begin
            outValid <= stageValid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            response <= '0;
        end else if (stageValid) begin
            response <= nextResponse;   // holds between requests
        end
    end

    // flags on a delivered response trace back to an add or sub in stage two
    assert property (@(posedge clk) disable iff (reset)
        outValid && (response.overflow || response.carryout)
            |-> $past(resultSel) == aluPkg::selSum);

endmodule

// ==== aluCore.sv ====
// ALU top level: control decoder, generated bit slices with chained carry, result collector
module aluCore (
    input  logic                clk,
    input  logic                reset,
    input  logic                inValid,
    input  aluPkg::aluRequestT  request,
    output logic                outValid,
    output aluPkg::aluResponseT response
);

    logic                          stageValid;
    aluPkg::aluControlT            control;
    logic [aluPkg::dataWidth-1:0]  inputA;
    logic [aluPkg::dataWidth-1:0]  inputB;
    logic [aluPkg::dataWidth-1:0]  sliceResults;
    logic [aluPkg::dataWidth-1:0]  sumWord;
    logic [aluPkg::sliceCount:0]   carryChain;     // carryChain[i] enters slice i
    logic [aluPkg::sliceCount-1:0] msbCarry;

    aluControlDecoder decoder (
        .clk        (clk),
        .reset      (reset),
        .inValid    (inValid),
        .request    (request),
        .stageValid (stageValid),
        .control    (control),
        .inputA     (inputA),
        .inputB     (inputB)
    );

    assign carryChain[0] = control.invertB;   // +1 completes two's complement on sub/slt

    for (genvar i = 0; i < aluPkg::sliceCount; i++) begin : sliceGen
        aluSlice slice (
            .a           (inputA[i*aluPkg::sliceWidth +: aluPkg::sliceWidth]),
            .b           (inputB[i*aluPkg::sliceWidth +: aluPkg::sliceWidth]),
            .carryIn     (carryChain[i]),
            .resultSel   (control.resultSel),
            .sliceResult (sliceResults[i*aluPkg::sliceWidth +: aluPkg::sliceWidth]),
            .sum         (sumWord[i*aluPkg::sliceWidth +: aluPkg::sliceWidth]),
            .carryOut    (carryChain[i+1]),
            .msbCarryIn  (msbCarry[i])
        );
    end

    aluResultCollector collector (
        .clk          (clk),
        .reset        (reset),
        .stageValid   (stageValid),
        .resultSel    (control.resultSel),
        .sliceResults (sliceResults),
        .sumMsb       (sumWord[aluPkg::dataWidth-1]),
        .carryOut     (carryChain[aluPkg::sliceCount]),
        .msbCarryIn   (msbCarry[aluPkg::sliceCount-1]),
        .outValid     (outValid),
        .response     (response)
    );

endmodule

// ==== aluTb.sv ====
// ALU testbench: stimulus table, random requests, reference model, latency and order checks
module aluTb;

    localparam int resetCycles    = 8;
    localparam int tableRows      = 23;
    localparam int randomCount    = 200;
    localparam int watchdogCycles = resetCycles + tableRows + randomCount + 20;

    typedef struct packed {
        logic                         valid;      // 0 leaves an idle cycle
        logic [aluPkg::dataWidth-1:0] operandA;
        logic [aluPkg::dataWidth-1:0] operandB;
        logic [aluPkg::cmdWidth-1:0]  command;
        aluPkg::aluResponseT          expected;
    } tableRowT;

    typedef struct packed {
        aluPkg::aluResponseT resp;
        int                  tag;     // edge that issued the request
    } expectT;

    logic                clk = 1'b0;
    logic                reset;
    logic                inValid;
    aluPkg::aluRequestT  request;
    logic                outValid;
    aluPkg::aluResponseT response;

    tableRowT rows [tableRows];
    string    rowNames [tableRows];
    int       rowFill = 0;
    int       edgeCount = 0;
    expectT   expectQ [$];
    string    nameQ [$];

    aluCore uut (
        .clk      (clk),
        .reset    (reset),
        .inValid  (inValid),
        .request  (request),
        .outValid (outValid),
        .response (response)
    );

    always #4 clk = ~clk;

    always @(posedge clk) edgeCount <= edgeCount + 1;

    task automatic reportFailure(input string message);
        $display("%s", message);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    function automatic string describeResponse(input aluPkg::aluResponseT r);
        return $sformatf("result=%h c=%b z=%b o=%b", r.result, r.carryout, r.zero, r.overflow);
    endfunction

    // expected response straight from the ALU's arithmetic rules
    function automatic aluPkg::aluResponseT computeExpected(
        input logic [aluPkg::dataWidth-1:0] a,
        input logic [aluPkg::dataWidth-1:0] b,
        input logic [aluPkg::cmdWidth-1:0]  cmd
    );
        aluPkg::aluResponseT r;
        logic [aluPkg::dataWidth:0] wide;
        r = '0;
        wide = '0;
        case (cmd)
            aluPkg::opAdd: begin
                wide       = {1'b0, a} + {1'b0, b};
                r.result   = wide[aluPkg::dataWidth-1:0];
                r.carryout = wide[aluPkg::dataWidth];
                r.overflow = (a[31] == b[31]) && (wide[31] != a[31]);
            end
            aluPkg::opSub: begin
                wide       = {1'b0, a} + {1'b0, ~b} + 33'd1;
                r.result   = wide[aluPkg::dataWidth-1:0];
                r.carryout = wide[aluPkg::dataWidth];
                r.overflow = (a[31] != b[31]) && (wide[31] != a[31]);   // sign of ~b
            end
            aluPkg::opSlt:  r.result = {31'b0, ($signed(a) < $signed(b))};
            aluPkg::opXor:  r.result = a ^ b;
            aluPkg::opAnd:  r.result = a & b;
            aluPkg::opNand: r.result = ~(a & b);
            aluPkg::opNor:  r.result = ~(a | b);
            default:        r.result = a | b;
        endcase
        r.zero = (r.result == '0);
        return r;
    endfunction

    // flags are {carryout, zero, overflow}
    task automatic addRow(input string name, input logic [31:0] a, input logic [31:0] b,
                          input logic [2:0] cmd, input logic [31:0] result, input logic [2:0] flags);
        rows[rowFill].valid    = 1'b1;
        rows[rowFill].operandA = a;
        rows[rowFill].operandB = b;
        rows[rowFill].command  = cmd;
        rows[rowFill].expected = {result, flags};
        rowNames[rowFill]      = name;
        rowFill++;
    endtask

    task automatic addIdle();
        rows[rowFill]     = '0;
        rowNames[rowFill] = "idleGap";
        rowFill++;
    endtask

    task automatic loadTable();
        addRow("addSmall",         32'h5,        32'h7,        aluPkg::opAdd,  32'hC,        3'b000);
        addRow("addCarry",         32'hFFFFFFFF, 32'h1,        aluPkg::opAdd,  32'h0,        3'b110);
        addRow("addOverflow",      32'h7FFFFFFF, 32'h1,        aluPkg::opAdd,  32'h80000000, 3'b001);
        addRow("addNegOverflow",   32'h80000000, 32'h80000000, aluPkg::opAdd,  32'h0,        3'b111);
        addRow("subBasic",         32'hA,        32'h3,        aluPkg::opSub,  32'h7,        3'b100);
        addRow("subEqual",         32'h12345678, 32'h12345678, aluPkg::opSub,  32'h0,        3'b110);
        addRow("subBorrow",        32'h3,        32'hA,        aluPkg::opSub,  32'hFFFFFFF9, 3'b000);
        addRow("subOverflowNeg",   32'h80000000, 32'h1,        aluPkg::opSub,  32'h7FFFFFFF, 3'b101);
        addRow("subOverflowPos",   32'h7FFFFFFF, 32'hFFFFFFFF, aluPkg::opSub,  32'h80000000, 3'b001);
        addRow("sltTrue",          32'h3,        32'h5,        aluPkg::opSlt,  32'h1,        3'b000);
        addRow("sltFalse",         32'h5,        32'h3,        aluPkg::opSlt,  32'h0,        3'b010);
        addRow("sltNegative",      32'hFFFFFFFF, 32'h1,        aluPkg::opSlt,  32'h1,        3'b000);
        addRow("sltOverflowTrue",  32'h80000000, 32'h1,        aluPkg::opSlt,  32'h1,        3'b000);
        addRow("sltOverflowFalse", 32'h7FFFFFFF, 32'h80000000, aluPkg::opSlt,  32'h0,        3'b010);
        addIdle();
        addRow("xorMixed",         32'hF0F0F0F0, 32'hFF00FF00, aluPkg::opXor,  32'h0FF00FF0, 3'b000);
        addRow("xorEqual",         32'hA5A5A5A5, 32'hA5A5A5A5, aluPkg::opXor,  32'h0,        3'b010);
        addRow("andMixed",         32'hF0F0F0F0, 32'hFF00FF00, aluPkg::opAnd,  32'hF000F000, 3'b000);
        addRow("andDisjoint",      32'h12345678, 32'hEDCBA987, aluPkg::opAnd,  32'h0,        3'b010);
        addRow("nandMixed",        32'hF0F0F0F0, 32'hFF00FF00, aluPkg::opNand, 32'h0FFF0FFF, 3'b000);
        addRow("norMixed",         32'hF0F0F0F0, 32'hFF00FF00, aluPkg::opNor,  32'h000F000F, 3'b000);
        addRow("norAllOnes",       32'hFFFFFFFF, 32'h0,        aluPkg::opNor,  32'h0,        3'b010);
        addRow("orMixed",          32'hF0F0F0F0, 32'hFF00FF00, aluPkg::opOr,   32'hFFF0FFF0, 3'b000);
    endtask

    task automatic sendRequest(input string name, input logic [31:0] a, input logic [31:0] b,
                               input logic [2:0] cmd, input aluPkg::aluResponseT expected);
        expectT entry;
        @(posedge clk);
        inValid <= 1'b1;
        request <= '{operandA: a, operandB: b, command: cmd};
        entry.resp = expected;
        entry.tag  = edgeCount + 1;   // edgeCount has not counted this edge yet
        expectQ.push_back(entry);
        nameQ.push_back(name);
    endtask

    task automatic idleCycle();
        @(posedge clk);
        inValid <= 1'b0;
        request <= '0;
    endtask

    // response checker, sampled away from the rising edge
    always @(negedge clk) begin
        expectT entry;
        string  name;
        int     lastEdge;
        lastEdge = edgeCount;
        if (outValid === 1'b1) begin
            assert (expectQ.size() != 0)
                else reportFailure("outValid went high with no request outstanding");
            entry = expectQ.pop_front();
            name  = nameQ.pop_front();
            assert (lastEdge == entry.tag + 2)
                else reportFailure($sformatf("mismatch in %s latency: expected %0d actual %0d",
                                             name, 2, lastEdge - entry.tag));
            assert (response === entry.resp)
                else reportFailure($sformatf("mismatch in %s: expected %s actual %s", name,
                                             describeResponse(entry.resp),
                                             describeResponse(response)));
        end else begin
            assert (outValid === 1'b0) else reportFailure("outValid is unknown");
            if (expectQ.size() != 0) begin
                assert (expectQ[0].tag + 2 > lastEdge)
                    else reportFailure($sformatf("response for %s never arrived", nameQ[0]));
            end
        end
    end

    initial begin
        #(watchdogCycles * 8);
        reportFailure("timeout: the run did not finish in time");
    end

    initial begin
        aluPkg::aluResponseT          modelResp;
        logic [aluPkg::dataWidth-1:0] a;
        logic [aluPkg::dataWidth-1:0] b;
        logic [aluPkg::cmdWidth-1:0]  cmd;
        void'($urandom(88031));
        reset     = 1'b1;
        inValid   = 1'b0;
        request   = '0;
        loadTable();
        // hand-written rows must agree with the model
        for (int i = 0; i < tableRows; i++) begin
            if (rows[i].valid) begin
                modelResp = computeExpected(rows[i].operandA, rows[i].operandB, rows[i].command);
                assert (modelResp == rows[i].expected)
                    else reportFailure($sformatf("mismatch in table row %s: expected %s actual %s",
                                                 rowNames[i], describeResponse(rows[i].expected),
                                                 describeResponse(modelResp)));
            end
        end
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < tableRows; i++) begin
            if (rows[i].valid) begin
                sendRequest(rowNames[i], rows[i].operandA, rows[i].operandB, rows[i].command,
                            rows[i].expected);
            end else begin
                idleCycle();
            end
        end
        for (int n = 0; n < randomCount; n++) begin
            a   = $urandom;
            b   = $urandom;
            cmd = 3'($urandom);
            if (($urandom % 8) == 0) begin
                b = a;   // equal operands hit the zero flag
            end
            sendRequest($sformatf("random%0d", n), a, b, cmd, computeExpected(a, b, cmd));
        end
        idleCycle();
        while (expectQ.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
aluPkg.sv
aluControlDecoder.sv
aluSlice.sv
aluResultCollector.sv
aluCore.sv
aluTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the ALU testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
{ verilator --binary --timing --assert --top-module aluTb -f vlog.f -o aluSim 2>&1 \
    && ./obj_dir/aluSim 2>&1 \
    || echo "Simulation failed"; } | tee sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0
